//--- source/ddc_pkg.sv
package ddc_pkg;

	// Channel count and sample widths
	localparam int N_CH    = 4;
	localparam int ADC_DW  = 16;  // ADC sample, signed
	localparam int LO_DW   = 18;  // LO sample, signed, full-scale negative not allowed

	// LO table geometry
	localparam int LO_LEN  = 8;   // Must stay even or mod2 breaks at the wrap
	localparam int LO_AW   = 3;

	// Record geometry
	localparam int REC_LEN   = 64;                 // Output words per record, half I half Q
	localparam int REC_CW    = $clog2(REC_LEN);    // Word counter in the averager
	localparam int REC_WRAPS = REC_LEN / LO_LEN;   // Table passes per record
	localparam int WRAP_CW   = $clog2(REC_WRAPS);

	// Datapath widths
	localparam int ACC_DW  = 23;                 // 16 data + 6 for 64 words + 1 guard
	localparam int PROD_DW = ADC_DW + LO_DW;     // Full multiplier product
	localparam int PROD_HI = PROD_DW - 2;        // Top bit is a copy of the sign without -FS LO
	localparam int SUM_DW  = ADC_DW + 1;         // Two-sample difference before saturation

	// Channel pipeline depth from ADC sample to the word that uses it as later sample
	localparam int CH_LAT  = 6;

	// LO sample broadcast to every channel
	typedef struct packed {
		logic signed [LO_DW-1:0] cos;
		logic signed [LO_DW-1:0] sin;
		logic                    mod2;  // Low on even phase, I is formed here
	} lo_sample_t;

	typedef logic [N_CH-1:0][ADC_DW-1:0] adc_bus_t;  // One signed sample per channel

	// Interleaved channel output
	typedef struct packed {
		logic signed [ADC_DW-1:0] data;
		logic                     iq_q;      // Set on Q words
		logic                     time_err;  // Phase slip or gate low
	} iq_word_t;

	// Host write port of the LO table
	typedef struct packed {
		logic                    wr;
		logic [LO_AW-1:0]        addr;
		logic signed [LO_DW-1:0] cos;
		logic signed [LO_DW-1:0] sin;
	} lo_wr_t;

	typedef struct packed {
		logic [N_CH-1:0][ACC_DW-1:0] i_sum;  // Two's complement sums
		logic [N_CH-1:0][ACC_DW-1:0] q_sum;
		logic [N_CH-1:0]             err;    // Sticky over the record
	} rec_result_t;

endpackage

//--- source/lo_table_player.sv
module lo_table_player
	import ddc_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  logic       run,        // Level, steps the table once per cycle
	input  lo_wr_t     lo_wr,      // Host write port
	output lo_sample_t lo,
	output logic       rec_start   // One cycle per record
);

	// LO table, host loaded
	// Entries are expected to avoid the most negative code
	logic signed [LO_DW-1:0] cos_tab [LO_LEN];
	logic signed [LO_DW-1:0] sin_tab [LO_LEN];

	logic [LO_AW-1:0]   rd_addr;   // Next entry to play
	logic [WRAP_CW-1:0] wrap_cnt;  // Table passes inside the current record
	logic               addr_last;
	logic               rec_mark;

	assign addr_last = (rd_addr == LO_AW'(LO_LEN - 1));

	// Record mark sits on the second sample of pass zero.
	// That is the later sample of the first pair, so the averager can
	// align the mark with one CH_LAT delay
	assign rec_mark = (rd_addr == LO_AW'(1)) && (wrap_cnt == '0);

	// Table write, readable at the next edge
	always_ff @(posedge clk) begin
		if (lo_wr.wr) begin
			cos_tab[lo_wr.addr] <= lo_wr.cos;
			sin_tab[lo_wr.addr] <= lo_wr.sin;
		end
	end

	// Playback
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_addr   <= '0;
			wrap_cnt  <= '0;
			lo        <= '0;  // mod2 starts low
			rec_start <= 1'b0;
		end else begin
			rec_start <= run && rec_mark;
			if (run) begin
				lo.cos  <= cos_tab[rd_addr];
				lo.sin  <= sin_tab[rd_addr];
				lo.mod2 <= rd_addr[0];  // Even length keeps this alternating
				if (addr_last) begin
					rd_addr <= '0;
					// Count passes, one record is REC_WRAPS passes
					if (wrap_cnt == WRAP_CW'(REC_WRAPS - 1)) begin
						wrap_cnt <= '0;
					end else begin
						wrap_cnt <= wrap_cnt + 1'b1;
					end
				end else begin
					rd_addr <= rd_addr + 1'b1;
				end
			end
			// Run low holds address and last sample
		end
	end

endmodule

//--- source/near_iq_channel.sv
module near_iq_channel
	import ddc_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  lo_sample_t               lo,
	input  logic signed [ADC_DW-1:0] adc,
	input  logic                     adc_gate,  // Low marks bad samples
	output iq_word_t                 iq
);

	// Two-sample matrix, n even, n+1 odd
	//   I =  sin[n+1]*x[n] - sin[n]*x[n+1]
	//   Q = -cos[n+1]*x[n] + cos[n]*x[n+1]
	// Each sample is multiplied by the LO of its partner

	logic signed [LO_DW-1:0]   cos_d1, cos_d2, cos_r;
	logic signed [LO_DW-1:0]   sin_d1, sin_d2, sin_r;
	logic signed [ADC_DW-1:0]  adc_d1, adc_r;
	logic signed [PROD_DW-1:0] mul_i, mul_i1, mul_i2;  // Sine products feed I
	logic signed [PROD_DW-1:0] mul_q, mul_q1, mul_q2;  // Cosine products feed Q
	logic signed [SUM_DW-1:0]  sum_i, sum_q, sum_q2;
	logic signed [SUM_DW-1:0]  iq_mux;
	logic signed [ADC_DW-1:0]  iq_data;
	logic                      iq_q_r;
	logic                      last_mod2;
	logic [CH_LAT-1:0]         err_pipe;  // Error aligned with the data path

	// Clip the 17-bit difference to 16 bits
	function automatic logic signed [ADC_DW-1:0] sat_word(input logic signed [SUM_DW-1:0] x);
		if (x[SUM_DW-1] == x[SUM_DW-2]) begin
			return x[ADC_DW-1:0];
		end
		return {x[SUM_DW-1], {(ADC_DW - 1){~x[SUM_DW-1]}}};  // Rail of matching sign
	endfunction

	// LO reorder. adc_d1 lags the LO by one sample.
	// mod2 high: adc_d1 is even, partner is the current LO
	// mod2 low: adc_d1 is odd, partner is two LO samples back
	always_ff @(posedge clk) begin
		cos_d1 <= lo.cos;
		cos_d2 <= cos_d1;
		sin_d1 <= lo.sin;
		sin_d2 <= sin_d1;
		cos_r  <= lo.mod2 ? lo.cos : cos_d2;
		sin_r  <= lo.mod2 ? lo.sin : sin_d2;
		adc_d1 <= adc;
		adc_r  <= adc_d1;  // Pairs with cos_r and sin_r
	end

	// Multiplier, then two extra stages so the pair sits side by side
	always_ff @(posedge clk) begin
		mul_i  <= adc_r * sin_r;
		mul_i1 <= mul_i;
		mul_i2 <= mul_i1;  // One sample older than mul_i1
		mul_q  <= adc_r * cos_r;
		mul_q1 <= mul_q;
		mul_q2 <= mul_q1;
	end

	// Differences on the upper product bits.
	// Valid when mul_i1 holds the odd sample. Q waits one more cycle
	always_ff @(posedge clk) begin
		sum_i  <= $signed(mul_i2[PROD_HI -: ADC_DW]) - $signed(mul_i1[PROD_HI -: ADC_DW]);
		sum_q  <= $signed(mul_q1[PROD_HI -: ADC_DW]) - $signed(mul_q2[PROD_HI -: ADC_DW]);
		sum_q2 <= sum_q;
	end

	// I on even LO phase, Q right after
	assign iq_mux = lo.mod2 ? sum_q2 : sum_i;

	always_ff @(posedge clk) begin
		iq_data <= sat_word(iq_mux);  // Only the difference can overflow
	end

	// Control state
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			iq_q_r    <= 1'b0;
			last_mod2 <= 1'b0;
			err_pipe  <= '0;
		end else begin
			iq_q_r    <= lo.mod2;  // Tags the word registered on this edge
			last_mod2 <= lo.mod2;
			// Phase must toggle every cycle and the gate must be open
			err_pipe  <= {err_pipe[CH_LAT-2:0], (lo.mod2 == last_mod2) | ~adc_gate};
		end
	end

	assign iq = '{data: iq_data, iq_q: iq_q_r, time_err: err_pipe[CH_LAT-1]};

endmodule

//--- source/iq_record_averager.sv
module iq_record_averager
	import ddc_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  iq_word_t    iq [N_CH],  // One interleaved stream per channel
	input  logic        rec_start,  // From the player, not yet aligned
	output rec_result_t result,
	output logic        rec_valid
);

	logic [CH_LAT-1:0]           start_sr;   // Matches the channel pipeline
	logic                        start_al;   // First word of a record is on iq now
	logic                        active;     // Inside a record
	logic                        last_word;
	logic [REC_CW-1:0]           word_cnt;
	logic [N_CH-1:0][ACC_DW-1:0] word_ext;   // Sign extended channel data
	logic [N_CH-1:0][ACC_DW-1:0] acc_i, acc_q;
	logic [N_CH-1:0][ACC_DW-1:0] nxt_i, nxt_q;
	logic [N_CH-1:0]             err_acc, nxt_err;

	assign start_al  = start_sr[CH_LAT-1];
	// A fresh start wins over a stale end
	assign last_word = active && !start_al && (word_cnt == REC_CW'(REC_LEN - 1));

	// Next sums, including the word on the bus this cycle
	always_comb begin
		for (int ch = 0; ch < N_CH; ch++) begin
			word_ext[ch] = {{(ACC_DW - ADC_DW){iq[ch].data[ADC_DW-1]}}, iq[ch].data};
			// Start of record drops the old sum
			nxt_i[ch]    = (start_al ? '0 : acc_i[ch]) + (iq[ch].iq_q ? '0 : word_ext[ch]);
			nxt_q[ch]    = (start_al ? '0 : acc_q[ch]) + (iq[ch].iq_q ? word_ext[ch] : '0);
			nxt_err[ch]  = (start_al ? 1'b0 : err_acc[ch]) | iq[ch].time_err;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			start_sr  <= '0;
			active    <= 1'b0;
			word_cnt  <= '0;
			acc_i     <= '0;
			acc_q     <= '0;
			err_acc   <= '0;
			result    <= '0;
			rec_valid <= 1'b0;
		end else begin
			start_sr  <= {start_sr[CH_LAT-2:0], rec_start};
			rec_valid <= last_word;  // One cycle after the last word

			// Record framing
			if (start_al) begin
				active   <= 1'b1;
				word_cnt <= REC_CW'(1);  // This cycle's word is number zero
			end else if (last_word) begin
				active   <= 1'b0;
				word_cnt <= '0;
			end else if (active) begin
				word_cnt <= word_cnt + 1'b1;
			end

			// Accumulate, or hand off and clear
			if (last_word) begin
				result.i_sum <= nxt_i;
				result.q_sum <= nxt_q;
				result.err   <= nxt_err;
				acc_i        <= '0;
				acc_q        <= '0;
				err_acc      <= '0;
			end else if (start_al || active) begin
				acc_i   <= nxt_i;
				acc_q   <= nxt_q;
				err_acc <= nxt_err;
			end
			// Outside a record the sums stay parked at zero
		end
	end

endmodule

//--- source/ddc_top.sv
module ddc_top
	import ddc_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        run,        // Level, LO plays while high
	input  lo_wr_t      lo_wr,      // Host LO table writes
	input  adc_bus_t    adc,        // One sample per channel per cycle
	input  logic        adc_gate,   // Shared by all channels
	output rec_result_t result,
	output logic        rec_valid
);

	lo_sample_t lo;          // Broadcast LO
	logic       rec_start;   // Record mark from the player
	iq_word_t   iq [N_CH];   // Channel streams into the averager

	lo_table_player i_lo_table_player (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.lo_wr     (lo_wr),
		.lo        (lo),
		.rec_start (rec_start)
	);

	// Same LO into every channel, own ADC slice each
	for (genvar ch = 0; ch < N_CH; ch++) begin : g_ch
		near_iq_channel i_near_iq_channel (
			.clk      (clk),
			.rst_n    (rst_n),
			.lo       (lo),
			.adc      (adc[ch]),
			.adc_gate (adc_gate),
			.iq       (iq[ch])
		);
	end

	// Sums per record, aligned to the channel latency inside
	iq_record_averager i_iq_record_averager (
		.clk       (clk),
		.rst_n     (rst_n),
		.iq        (iq),
		.rec_start (rec_start),
		.result    (result),
		.rec_valid (rec_valid)
	);

endmodule

//--- tests/ddc_props.sv
module ddc_props (
	input logic clk,
	input logic rst_n,
	input logic run,
	input logic mod2,       // LO phase bit from the player
	input logic rec_valid
);
	timeunit 1ns;
	timeprecision 100ps;

	// First LO sample lands one cycle after run, so look two back
	property p_mod2_toggles;
		@(posedge clk) disable iff (!rst_n)
			run && $past(run) && $past(run, 2) |-> mod2 != $past(mod2);
	endproperty

	property p_valid_single;
		@(posedge clk) disable iff (!rst_n)
			rec_valid |=> !rec_valid;
	endproperty

	// Checked on edges inside reset
	property p_valid_reset;
		@(posedge clk)
			!rst_n |-> !rec_valid;
	endproperty

	a_mod2_toggles: assert property (p_mod2_toggles)
		else $error("LO phase bit held while run was high");

	a_valid_single: assert property (p_valid_single)
		else $error("rec_valid stayed high for more than one cycle");

	a_valid_reset: assert property (p_valid_reset)
		else $error("rec_valid high during reset");

endmodule

//--- tests/ddc_tb.sv
module ddc_tb
	import ddc_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int MAX_REC = 8;
	localparam int N_PAT   = 4;
	localparam int WAIT_MAX = REC_LEN + CH_LAT + 10;  // Cycles allowed per record

	logic        clk;
	logic        rst_n;
	logic        run;
	lo_wr_t      lo_wr;
	adc_bus_t    adc;
	logic        adc_gate;
	rec_result_t result;
	logic        rec_valid;

	// Stimulus tables filled from the data file
	int lo_cos   [2][LO_LEN];       // Two LO sets
	int lo_sin   [2][LO_LEN];
	int pat_adc  [N_PAT][LO_LEN][N_CH];
	bit pat_gate [N_PAT][LO_LEN];
	int rec_pat  [MAX_REC];         // ADC pattern per record
	int rec_set  [MAX_REC];         // LO set per record
	int exp_i    [MAX_REC][N_CH];
	int exp_q    [MAX_REC][N_CH];
	int exp_err  [MAX_REC];
	int n_rec    = 0;
	int errors   = 0;
	int cyc      = 0;  // Rising edges since time zero
	int run_cyc  = 0;  // Edge where playback starts
	bit loaded   = 0;

	ddc_top i_ddc_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.lo_wr     (lo_wr),
		.adc       (adc),
		.adc_gate  (adc_gate),
		.result    (result),
		.rec_valid (rec_valid)
	);

	bind ddc_top ddc_props i_ddc_props (
		.clk       (clk),
		.rst_n     (rst_n),
		.run       (run),
		.mod2      (lo.mod2),
		.rec_valid (rec_valid)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	// Parse tagged rows and skip lines starting with #
	task automatic read_stim();
		int    fd;
		int    n;
		int    v [12];
		string line;
		fd = $fopen("tests/ddc_stim.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tests/ddc_stim.txt");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "#") continue;
			if (line[0] == "L") begin
				n = $sscanf(line, "L %d %d %d %d", v[0], v[1], v[2], v[3]);
				lo_cos[v[0]][v[1]] = v[2];
				lo_sin[v[0]][v[1]] = v[3];
			end else if (line[0] == "A") begin
				n = $sscanf(line, "A %d %d %d %d %d %d %d",
					v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
				for (int ch = 0; ch < N_CH; ch++) pat_adc[v[0]][v[1]][ch] = v[2+ch];
				pat_gate[v[0]][v[1]] = v[6][0];
			end else if (line[0] == "E") begin
				n = $sscanf(line, "E %d %d %d %d %d %d %d %d %d %d %d %h", v[0], v[1],
					v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
				rec_pat[v[0]] = v[1];
				rec_set[v[0]] = v[2];
				for (int ch = 0; ch < N_CH; ch++) begin
					exp_i[v[0]][ch] = v[3+ch];
					exp_q[v[0]][ch] = v[7+ch];
				end
				exp_err[v[0]] = v[11];
				if (v[0] + 1 > n_rec) n_rec = v[0] + 1;
			end
		end
		$fclose(fd);
	endtask

	// Host write of one LO entry in the current slot
	task automatic put_lo(input int set, input int addr);
		lo_wr.wr   = 1'b1;
		lo_wr.addr = LO_AW'(addr);
		lo_wr.cos  = LO_DW'(lo_cos[set][addr]);
		lo_wr.sin  = LO_DW'(lo_sin[set][addr]);
	endtask

	// One ADC row per cycle with the phase of that cycle's LO entry
	task automatic drive_records();
		int c;
		int r;
		int ph;
		int last;
		int bound;
		last = n_rec * REC_LEN + CH_LAT + 4;
		for (c = 0; c < last; c++) begin
			r = c / REC_LEN;
			if (r >= n_rec) r = n_rec - 1;
			ph = c % LO_LEN;
			for (int ch = 0; ch < N_CH; ch++) adc[ch] = ADC_DW'(pat_adc[rec_pat[r]][ph][ch]);
			adc_gate = pat_gate[rec_pat[r]][ph];
			lo_wr = '0;
			bound = REC_LEN * (r + 1);
			// Each entry of a new LO set lands on the edge that last reads the old one
			if (r + 1 < n_rec && rec_set[r+1] != rec_set[r] &&
					c >= bound - LO_LEN - 1 && c < bound - 1) begin
				put_lo(rec_set[r+1], (c + 1) % LO_LEN);
			end
			@(posedge clk);
			#5;
		end
	endtask

	task automatic check_records();
		int r;
		int wait_n;
		int want_cyc;
		for (r = 0; r < n_rec; r++) begin
			wait_n = 0;
			@(negedge clk);
			while (rec_valid !== 1'b1 && wait_n < WAIT_MAX) begin
				@(negedge clk);
				wait_n++;
			end
			if (rec_valid !== 1'b1) begin
				$display("No rec_valid pulse arrived for record %0d", r);
				errors++;
				return;
			end
			// Record start one cycle after run plus channel delay and whole records
			want_cyc = run_cyc + 1 + CH_LAT + REC_LEN * (r + 1);
			if (cyc != want_cyc) begin
				$display("[ERROR] %0t: record %0d rec_valid at cycle %0d, expected %0d",
					$time, r, cyc - run_cyc, want_cyc - run_cyc);
				errors++;
			end
			for (int ch = 0; ch < N_CH; ch++) begin
				if ($signed(result.i_sum[ch]) != exp_i[r][ch]) begin
					$display("[ERROR] %0t: record %0d ch %0d I sum %0d, expected %0d",
						$time, r, ch, $signed(result.i_sum[ch]), exp_i[r][ch]);
					errors++;
				end
				if ($signed(result.q_sum[ch]) != exp_q[r][ch]) begin
					$display("[ERROR] %0t: record %0d ch %0d Q sum %0d, expected %0d",
						$time, r, ch, $signed(result.q_sum[ch]), exp_q[r][ch]);
					errors++;
				end
			end
			if (result.err !== N_CH'(exp_err[r])) begin
				$display("[ERROR] %0t: record %0d err %b, expected %b",
					$time, r, result.err, N_CH'(exp_err[r]));
				errors++;
			end
		end
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		run      = 1'b0;
		lo_wr    = '0;
		adc      = '0;
		adc_gate = 1'b1;
		read_stim();
		loaded = 1'b1;

		// Outputs quiet while in reset
		@(negedge clk);
		if (rec_valid !== 1'b0 || result !== '0) begin
			$display("[ERROR] %0t: outputs not cleared in reset", $time);
			errors++;
		end
		@(posedge clk);  // Second rising edge in reset
		#5;
		rst_n = 1'b1;

		// Initial LO table
		for (int e = 0; e < LO_LEN; e++) begin
			put_lo(rec_set[0], e);
			@(posedge clk);
			#5;
		end
		lo_wr   = '0;
		run     = 1'b1;
		run_cyc = cyc + 1;
		@(posedge clk);
		#5;

		fork
			drive_records();
			check_records();
		join

		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the record count
	initial begin
		longint limit_ns;
		wait (loaded);
		limit_ns = (n_rec * WAIT_MAX + 20) * 100;
		#(limit_ns);
		$display("Watchdog expired before all records were checked");
		$display("Test failed");
		$finish;
	end

endmodule

//--- tests/ddc_stim.txt
# L set addr cos sin | A pattern phase adc0 adc1 adc2 adc3 gate
# E record pattern lo_set i0 i1 i2 i3 q0 q1 q2 q3 err_hex
L 0 0 65536 0
L 0 1 65536 65536
L 0 2 0 65536
L 0 3 -65536 65536
L 0 4 -65536 0
L 0 5 -65536 -65536
L 0 6 0 -65536
L 0 7 65536 -65536
L 1 0 131071 0
L 1 1 131071 131071
L 1 2 0 131071
L 1 3 -131071 131071
L 1 4 -131071 0
L 1 5 -131071 -131071
L 1 6 0 -131071
L 1 7 131071 -131071
A 0 0 1000 -2000 30000 -32768 1
A 0 1 1000 -2000 30000 -32768 1
A 0 2 1000 -2000 30000 -32768 1
A 0 3 1000 -2000 30000 -32768 1
A 0 4 1000 -2000 30000 -32768 1
A 0 5 1000 -2000 30000 -32768 1
A 0 6 1000 -2000 30000 -32768 1
A 0 7 1000 -2000 30000 -32768 1
A 1 0 0 2000 0 6000 1
A 1 1 1000 2000 -4000 6000 1
A 1 2 1000 0 -4000 6000 1
A 1 3 1000 -2000 -4000 0 1
A 1 4 0 -2000 0 -6000 1
A 1 5 -1000 -2000 4000 -6000 1
A 1 6 -1000 0 4000 -6000 1
A 1 7 -1000 2000 4000 0 1
A 2 0 0 2000 0 6000 1
A 2 1 1000 2000 -4000 6000 1
A 2 2 1000 0 -4000 6000 1
A 2 3 1000 -2000 -4000 0 0
A 2 4 0 -2000 0 -6000 1
A 2 5 -1000 -2000 4000 -6000 1
A 2 6 -1000 0 4000 -6000 1
A 2 7 -1000 2000 4000 0 1
A 3 0 32767 -32768 32767 -32768 1
A 3 1 32767 -32768 32767 -32768 1
A 3 2 32767 -32768 32767 -32768 1
A 3 3 -32768 32767 32767 -32768 1
A 3 4 -32768 32767 32767 -32768 1
A 3 5 -32768 32767 32767 -32768 1
A 3 6 -32768 32767 32767 -32768 1
A 3 7 32767 -32768 32767 -32768 1
E 0 0 0 0 0 0 0 0 0 0 0 0
E 1 1 0 0 32000 0 96000 16000 0 -64000 48000 0
E 2 2 0 0 32000 0 96000 16000 0 -64000 48000 f
E 3 1 0 0 32000 0 96000 16000 0 -64000 48000 0
E 4 1 1 0 63984 0 191968 31984 0 -127984 96000 0
E 5 3 1 1048536 -1048568 -8 -8 524272 -524264 8 0 0

//--- src.f
source/ddc_pkg.sv
source/lo_table_player.sv
source/near_iq_channel.sv
source/iq_record_averager.sv
source/ddc_top.sv
tests/ddc_props.sv
tests/ddc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module ddc_tb -f src.f -o ddc_sim
./obj_dir/ddc_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1
